/* epdc_pkg.sv */
package epdc_pkg;

    //////////////////////////////////////////////////
    // Pixel and source-data words
    //////////////////////////////////////////////////

    // 0 is black, 15 is white
    typedef logic [3:0] gray_t;

    // One video beat, also one word of panel state
    typedef gray_t [3:0] beat_t;

    typedef enum logic [1:0] {
        drive_noop    = 2'd0,
        drive_darken  = 2'd1,
        drive_lighten = 2'd2
    } drive_t;

    typedef drive_t [3:0] sd_word_t;

    //////////////////////////////////////////////////
    // Panel strobes and internal links
    //////////////////////////////////////////////////

    // sdce0 is active low, all others active high
    typedef struct packed {
        logic gdoe;
        logic gdclk;
        logic gdsp;
        logic sdle;
        logic sdoe;
        logic sdce0;
    } epd_bus_t;

    typedef struct packed {
        logic        fire;
        logic [15:0] addr;
    } scan_beat_t;

    typedef struct packed {
        logic       start;
        logic [7:0] frames_req;
    } scan_cfg_t;

    typedef struct packed {
        logic busy;
        logic frame_done;
    } scan_stat_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        reg_ctrl   = 4'h0,
        reg_frames = 4'h4,
        reg_status = 4'h8,
        reg_count  = 4'hC
    } reg_addr_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2
    } axil_resp_e;

endpackage

/* epdc_regs.sv */
`timescale 1ns/1ps

module epdc_regs
    import epdc_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [3:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [3:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    output scan_cfg_t   cfg,
    input  scan_stat_t  stat
);

    logic        aw_held;
    logic        w_held;
    logic [3:0]  awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        aw_take;
    logic        w_take;
    logic        wr_fire;
    logic [3:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        start_req;
    logic        start_pulse;
    logic [7:0]  frames_q;
    logic [31:0] frame_cnt;
    logic [31:0] rd_data;
    axil_resp_e  rd_resp;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////

    // Stall both channels while a response is pending
    assign s_axil_awready = !aw_held && !s_axil_bvalid;
    assign s_axil_wready  = !w_held && !s_axil_bvalid;
    assign aw_take        = s_axil_awvalid && s_axil_awready;
    assign w_take         = s_axil_wvalid && s_axil_wready;

    // Address and data may come in either order
    assign wr_addr = aw_held ? awaddr_q : s_axil_awaddr;
    assign wr_data = w_held ? wdata_q : s_axil_wdata;
    assign wr_strb = w_held ? wstrb_q : s_axil_wstrb;
    assign wr_fire = (aw_held || aw_take) && (w_held || w_take);

    always_ff @(posedge clk_sys) begin
        if (aw_take) begin
            awaddr_q <= s_axil_awaddr;
        end
        if (w_take) begin
            wdata_q <= s_axil_wdata;
            wstrb_q <= s_axil_wstrb;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            aw_held       <= 1'b0;
            w_held        <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp  <= resp_okay;
            start_req     <= 1'b0;
            start_pulse   <= 1'b0;
            frames_q      <= 8'd0;
        end else begin
            start_req   <= 1'b0;
            start_pulse <= start_req;
            if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (wr_fire) begin
                aw_held       <= 1'b0;
                w_held        <= 1'b0;
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= resp_okay;
                case (wr_addr)
                    reg_ctrl:   start_req <= wr_strb[0] && wr_data[0];
                    reg_frames: begin
                        if (wr_strb[0]) begin
                            frames_q <= wr_data[7:0];
                        end
                    end
                    // Read-only, write is dropped
                    reg_status, reg_count: ;
                    default:    s_axil_bresp <= resp_slverr;
                endcase
            end else begin
                if (aw_take) begin
                    aw_held <= 1'b1;
                end
                if (w_take) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    assign cfg = '{start: start_pulse, frames_req: frames_q};

    // Completed frames since the last accepted start
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            frame_cnt <= 32'd0;
        end else if (cfg.start && !stat.busy) begin
            frame_cnt <= 32'd0;
        end else if (stat.frame_done) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////

    assign s_axil_arready = !s_axil_rvalid;

    always_comb begin
        rd_data = 32'd0;
        rd_resp = resp_okay;
        case (s_axil_araddr)
            reg_ctrl:   rd_data = 32'd0;
            reg_frames: rd_data = {24'd0, frames_q};
            reg_status: rd_data = {31'd0, stat.busy};
            reg_count:  rd_data = frame_cnt;
            default:    rd_resp = resp_slverr;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            s_axil_rvalid <= 1'b0;
        end else if (s_axil_arvalid && s_axil_arready) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (s_axil_arvalid && s_axil_arready) begin
            s_axil_rdata <= rd_data;
            s_axil_rresp <= rd_resp;
        end
    end

    // Responses hold steady until the master takes them
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));

    assert property (@(posedge clk_sys) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

/* epdc_scan_timing.sv */
`timescale 1ns/1ps

module epdc_scan_timing
    import epdc_pkg::*;
#(
    parameter int H_FP   = 2,
    parameter int H_SYNC = 1,
    parameter int H_BP   = 2,
    parameter int H_ACT  = 4,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1,
    parameter int V_ACT  = 4
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  scan_cfg_t  cfg,
    output scan_stat_t stat,
    input  logic       vin_valid,
    output logic       vin_ready,
    output scan_beat_t beat,
    output epd_bus_t   epd
);

    // Line order is sync, back porch, active, front porch
    localparam logic [15:0] H_A0     = 16'(H_SYNC + H_BP);
    localparam logic [15:0] H_A1     = 16'(H_SYNC + H_BP + H_ACT);
    localparam logic [15:0] H_LAST_A = 16'(H_SYNC + H_BP + H_ACT - 1);
    localparam logic [15:0] H_END    = 16'(H_SYNC + H_BP + H_ACT + H_FP - 1);
    localparam logic [15:0] V_A0     = 16'(V_SYNC + V_BP);
    localparam logic [15:0] V_A1     = 16'(V_SYNC + V_BP + V_ACT);
    localparam logic [15:0] V_END    = 16'(V_SYNC + V_BP + V_ACT + V_FP - 1);

    typedef enum logic {
        st_idle,
        st_scan
    } run_state_e;

    run_state_e  state;
    logic [15:0] h_pos;
    logic [15:0] v_pos;
    logic [7:0]  frames_left;
    logic        scanning;
    logic        h_act;
    logic        v_act;
    logic        at_active;
    logic        advance;
    logic        line_end;
    logic        frame_end;
    logic        frame_done_q;
    logic        last_beat_q;

    assign scanning  = state == st_scan;
    assign h_act     = (h_pos >= H_A0) && (h_pos < H_A1);
    assign v_act     = (v_pos >= V_A0) && (v_pos < V_A1);
    assign at_active = scanning && h_act && v_act;
    assign line_end  = h_pos == H_END;
    assign frame_end = line_end && (v_pos == V_END);

    // Active positions wait for a beat, the rest step every cycle
    assign advance   = scanning && (!at_active || vin_valid);
    assign vin_ready = at_active;

    assign beat.fire = at_active && vin_valid;
    assign beat.addr = 16'((v_pos - V_A0) * H_ACT + (h_pos - H_A0));

    assign stat = '{busy: scanning, frame_done: frame_done_q};

    //////////////////////////////////////////////////
    // Run control and position counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state        <= st_idle;
            h_pos        <= 16'd0;
            v_pos        <= 16'd0;
            frames_left  <= 8'd0;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= 1'b0;
            case (state)
                st_idle: begin
                    // Zero frames means nothing to do
                    if (cfg.start && cfg.frames_req != 8'd0) begin
                        state       <= st_scan;
                        h_pos       <= 16'd0;
                        v_pos       <= 16'd0;
                        frames_left <= cfg.frames_req;
                    end
                end
                st_scan: begin
                    if (advance) begin
                        if (line_end) begin
                            h_pos <= 16'd0;
                            if (frame_end) begin
                                v_pos        <= 16'd0;
                                frame_done_q <= 1'b1;
                                frames_left  <= frames_left - 8'd1;
                                if (frames_left == 8'd1) begin
                                    state <= st_idle;
                                end
                            end else begin
                                v_pos <= v_pos + 16'd1;
                            end
                        end else begin
                            h_pos <= h_pos + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Panel strobes, one cycle behind the position
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            epd         <= '{gdoe: 1'b0, gdclk: 1'b0, gdsp: 1'b0,
                             sdle: 1'b0, sdoe: 1'b0, sdce0: 1'b1};
            last_beat_q <= 1'b0;
        end else begin
            last_beat_q <= beat.fire && (h_pos == H_LAST_A);
            epd.gdoe    <= scanning;
            epd.gdsp    <= scanning && (h_pos == 16'd0) && (v_pos == 16'd0);
            epd.gdclk   <= scanning && (h_pos == 16'd0);
            // Latch after the sdclk of the last beat in the line
            epd.sdle    <= last_beat_q;
            epd.sdoe    <= scanning && v_act;
            epd.sdce0   <= !at_active;
        end
    end

    // Beats only while frames of the run remain
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        beat.fire |-> frames_left != 8'd0);

    // Latch comes two cycles after the last beat and never on a beat
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        epd.sdle |-> !beat.fire && $past(beat.fire, 2));

endmodule

/* epdc_top.sv */
`timescale 1ns/1ps

module epdc_top
    import epdc_pkg::*;
#(
    parameter int H_FP   = 2,
    parameter int H_SYNC = 1,
    parameter int H_BP   = 2,
    parameter int H_ACT  = 4,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1,
    parameter int V_ACT  = 4
) (
    input  logic        clk_sys,
    input  logic        rst_n,
    // AXI4-Lite register port
    input  logic [3:0]  s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [3:0]  s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    // Video input, resent every frame
    input  beat_t       vin_pixel,
    input  logic        vin_valid,
    output logic        vin_ready,
    // Panel
    output epd_bus_t    epd,
    output logic        epd_sdclk,
    output sd_word_t    epd_sd
);

    scan_cfg_t  cfg;
    scan_stat_t stat;
    scan_beat_t beat;

    epdc_regs epdc_regs_i (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .cfg            (cfg),
        .stat           (stat)
    );

    epdc_scan_timing #(
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT)
    ) epdc_scan_timing_i (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .stat      (stat),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .beat      (beat),
        .epd       (epd)
    );

    // State memory sized by the active area
    epdc_waveform #(
        .H_ACT (H_ACT),
        .V_ACT (V_ACT)
    ) epdc_waveform_i (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .beat      (beat),
        .vin_pixel (vin_pixel),
        .epd_sdclk (epd_sdclk),
        .epd_sd    (epd_sd)
    );

endmodule

/* epdc_waveform.sv */
`timescale 1ns/1ps

module epdc_waveform
    import epdc_pkg::*;
#(
    parameter int H_ACT = 4,
    parameter int V_ACT = 4
) (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  scan_beat_t beat,
    input  beat_t      vin_pixel,
    output logic       epd_sdclk,
    output sd_word_t   epd_sd
);

    localparam int N_BEATS = H_ACT * V_ACT;
    localparam int AW      = (N_BEATS > 1) ? $clog2(N_BEATS) : 1;

    // Current panel gray level, one word per beat address
    beat_t         level_mem [N_BEATS];
    logic [AW-1:0] idx;
    beat_t         cur_lvl;
    beat_t         nxt_lvl;
    sd_word_t      code;

    assign idx     = beat.addr[AW-1:0];
    assign cur_lvl = level_mem[idx];

    //////////////////////////////////////////////////
    // Drive code per pixel
    //////////////////////////////////////////////////

    // Each frame moves the stored level one step toward the target
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (vin_pixel[i] > cur_lvl[i]) begin
                code[i]    = drive_lighten;
                nxt_lvl[i] = cur_lvl[i] + 4'd1;
            end else if (vin_pixel[i] < cur_lvl[i]) begin
                code[i]    = drive_darken;
                nxt_lvl[i] = cur_lvl[i] - 4'd1;
            end else begin
                code[i]    = drive_noop;
                nxt_lvl[i] = cur_lvl[i];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            // All pixels start white
            for (int i = 0; i < N_BEATS; i++) begin
                level_mem[i] <= '1;
            end
        end else if (beat.fire) begin
            level_mem[idx] <= nxt_lvl;
        end
    end

    //////////////////////////////////////////////////
    // Source driver output
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            epd_sdclk <= 1'b0;
        end else begin
            epd_sdclk <= beat.fire;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (beat.fire) begin
            epd_sd <= code;
        end
    end

    // Scan addresses must land inside the state memory
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        beat.fire |-> beat.addr < 16'(N_BEATS));

endmodule

/* flist.f */
epdc_pkg.sv
epdc_regs.sv
epdc_scan_timing.sv
epdc_waveform.sv
epdc_top.sv
tb_clkgen.sv
tb_epdc.sv

/* run.sh */
#!/bin/sh
# Build and run the EPD controller testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 --top-module tb_epdc -f flist.f -o tb_epdc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_epdc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_sys,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // Reset held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_sys);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* tb_epdc.sv */
`timescale 1ns/1ps

module tb_epdc
    import epdc_pkg::*;
();

    localparam int H_FP      = 2;
    localparam int H_SYNC    = 1;
    localparam int H_BP      = 2;
    localparam int H_ACT     = 4;
    localparam int V_FP      = 1;
    localparam int V_SYNC    = 1;
    localparam int V_BP      = 1;
    localparam int V_ACT     = 4;
    localparam int N_BEATS   = H_ACT * V_ACT;
    localparam int V_TOTAL   = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int FRAME_POS = (H_SYNC + H_BP + H_ACT + H_FP) * V_TOTAL;
    localparam int N_IMG     = 4;
    localparam int N_ROWS    = 6;

    typedef struct packed {
        int img;
        int frames;
        int exp_count;
        bit gaps;
        bit settle;
    } row_t;

    // Images: 0 black, 1 random, 2 white, 3 mid gray
    localparam row_t ROWS [N_ROWS] = '{
        '{img: 1, frames: 3,  exp_count: 3,  gaps: 1'b0, settle: 1'b0},
        '{img: 0, frames: 16, exp_count: 16, gaps: 1'b0, settle: 1'b1},
        '{img: 1, frames: 4,  exp_count: 4,  gaps: 1'b1, settle: 1'b0},
        '{img: 2, frames: 2,  exp_count: 2,  gaps: 1'b1, settle: 1'b0},
        '{img: 3, frames: 0,  exp_count: 0,  gaps: 1'b0, settle: 1'b0},
        '{img: 3, frames: 9,  exp_count: 9,  gaps: 1'b1, settle: 1'b0}
    };

    logic        clk_sys;
    logic        rst_n;
    logic [3:0]  s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [3:0]  s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;
    beat_t       vin_pixel;
    logic        vin_valid;
    logic        vin_ready;
    epd_bus_t    epd;
    logic        epd_sdclk;
    sd_word_t    epd_sd;

    logic [31:0] rng_state;
    beat_t       images [N_IMG][N_BEATS];

    // Reference model and strobe counters, owned by the monitor
    beat_t       model_lvl [N_BEATS];
    int          model_addr;
    sd_word_t    exp_q [$];
    int          n_sdclk;
    int          n_gdsp;
    int          n_gdclk;
    int          n_sdle;
    int          noop_streak;
    logic        ready_q;

    tb_clkgen tb_clkgen_i (
        .clk_sys (clk_sys),
        .rst_n   (rst_n)
    );

    epdc_top epdc_top_i (.*);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_sd(input sd_word_t got, input sd_word_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input axil_resp_e got_resp,
                             input logic [31:0] exp, input axil_resp_e exp_resp,
                             input string what);
        if (got !== exp || got_resp !== exp_resp) begin
            report_error($sformatf("%s: got %h/%0d, expected %h/%0d",
                                   what, got, got_resp, exp, exp_resp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // One frame step toward the target per pixel
    function automatic sd_word_t model_apply(input beat_t tgt, input beat_t lvl,
                                             output beat_t nxt);
        sd_word_t codes;
        int       diff;
        for (int i = 0; i < 4; i++) begin
            diff = int'(tgt[i]) - int'(lvl[i]);
            if (diff > 0) begin
                codes[i] = drive_lighten;
                nxt[i]   = lvl[i] + 4'd1;
            end else if (diff < 0) begin
                codes[i] = drive_darken;
                nxt[i]   = lvl[i] - 4'd1;
            end else begin
                codes[i] = drive_noop;
                nxt[i]   = lvl[i];
            end
        end
        return codes;
    endfunction

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output axil_resp_e resp);
        bit aw_done;
        bit w_done;
        aw_done        = 1'b0;
        w_done         = 1'b0;
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hF;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk_sys);
            if (s_axil_awvalid && s_axil_awready) begin
                aw_done = 1'b1;
            end
            if (s_axil_wvalid && s_axil_wready) begin
                w_done = 1'b1;
            end
            @(posedge clk_sys);
            #2;
            if (aw_done) begin
                s_axil_awvalid = 1'b0;
            end
            if (w_done) begin
                s_axil_wvalid = 1'b0;
            end
        end
        do begin
            @(negedge clk_sys);
        end while (!s_axil_bvalid);
        resp = axil_resp_e'(s_axil_bresp);
        @(posedge clk_sys);
        #2;
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        do begin
            @(negedge clk_sys);
        end while (!s_axil_arready);
        @(posedge clk_sys);
        #2;
        s_axil_arvalid = 1'b0;
        do begin
            @(negedge clk_sys);
        end while (!s_axil_rvalid);
        data = s_axil_rdata;
        resp = axil_resp_e'(s_axil_rresp);
        @(posedge clk_sys);
        #2;
        s_axil_rready = 1'b0;
    endtask

    task automatic poll_busy(input logic level);
        logic [31:0] data;
        axil_resp_e  resp;
        do begin
            axil_read(reg_status, data, resp);
            check_reg(data & 32'hFFFF_FFFE, resp, 32'd0, resp_okay, "status poll");
        end while (data[0] !== level);
    endtask

    // A beat not yet taken keeps valid high and its pixels unchanged
    task automatic send_video(input int img, input int frames, input bit gaps);
        int          k;
        int          sent;
        bit          pend;
        logic [31:0] r;
        k    = 0;
        sent = 0;
        pend = 1'b0;
        while (sent < frames * N_BEATS) begin
            vin_pixel = images[img][k];
            if (!pend) begin
                r         = xorshift32();
                vin_valid = !gaps || (r[1:0] != 2'd0);
            end
            @(negedge clk_sys);
            pend = vin_valid && !vin_ready;
            if (vin_valid && vin_ready) begin
                k = (k + 1) % N_BEATS;
                sent++;
            end
            @(posedge clk_sys);
            #2;
        end
        vin_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Monitor, sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clk_sys) begin : monitor
        sd_word_t codes;
        beat_t    nxt;
        if (!rst_n) begin
            for (int i = 0; i < N_BEATS; i++) begin
                model_lvl[i] = '1;
            end
            model_addr  = 0;
            n_sdclk     = 0;
            n_gdsp      = 0;
            n_gdclk     = 0;
            n_sdle      = 0;
            noop_streak = 0;
            ready_q     = 1'b0;
        end else begin
            // Strobes trail the scan position by one cycle
            check_count(int'(epd.sdce0), int'(!ready_q), "sdce0 against active positions");
            ready_q = vin_ready;
            if (vin_valid && vin_ready) begin
                codes                 = model_apply(vin_pixel, model_lvl[model_addr], nxt);
                model_lvl[model_addr] = nxt;
                exp_q.push_back(codes);
                model_addr = (model_addr + 1) % N_BEATS;
            end
            if (epd_sdclk) begin
                n_sdclk++;
                check_count(int'(epd.sdoe), 1, "sdoe level during sdclk");
                check_count(int'(exp_q.size() != 0), 1, "beat queued for sdclk");
                check_sd(epd_sd, exp_q.pop_front(), "source data");
                if (epd_sd == {drive_noop, drive_noop, drive_noop, drive_noop}) begin
                    noop_streak++;
                end else begin
                    noop_streak = 0;
                end
            end
            if (epd.gdsp) begin
                n_gdsp++;
            end
            if (epd.gdclk) begin
                n_gdclk++;
                check_count(int'(epd.gdoe), 1, "gdoe level during gdclk");
            end
            if (epd.sdle) begin
                n_sdle++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin : main
        axil_resp_e  resp;
        logic [31:0] data;
        logic [31:0] r;
        row_t        row;
        int          b_sdclk;
        int          b_gdsp;
        int          b_gdclk;
        int          b_sdle;

        rng_state      = 32'd74766;
        s_axil_awaddr  = 4'h0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = 32'd0;
        s_axil_wstrb   = 4'h0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = 4'h0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        vin_pixel      = '0;
        vin_valid      = 1'b0;

        for (int k = 0; k < N_BEATS; k++) begin
            r            = xorshift32();
            images[0][k] = '0;
            images[1][k] = r[15:0];
            images[2][k] = '1;
            images[3][k] = {4{4'd7}};
        end

        wait (rst_n === 1'b1);
        @(posedge clk_sys);
        #2;

        // Register map
        axil_read(reg_status, data, resp);
        check_reg(data, resp, 32'd0, resp_okay, "status after reset");
        axil_read(reg_count, data, resp);
        check_reg(data, resp, 32'd0, resp_okay, "count after reset");
        axil_write(reg_frames, 32'h0000_00A5, resp);
        check_reg(32'd0, resp, 32'd0, resp_okay, "frames write");
        axil_read(reg_frames, data, resp);
        check_reg(data, resp, 32'h0000_00A5, resp_okay, "frames readback");
        axil_write(4'h2, 32'd1, resp);
        check_reg(32'd0, resp, 32'd0, resp_slverr, "write to 0x2");
        axil_read(4'h2, data, resp);
        check_reg(data, resp, 32'd0, resp_slverr, "read of 0x2");

        for (int i = 0; i < N_ROWS; i++) begin
            row = ROWS[i];
            axil_write(reg_frames, 32'(row.frames), resp);
            check_reg(32'd0, resp, 32'd0, resp_okay, "frames write");
            b_sdclk = n_sdclk;
            b_gdsp  = n_gdsp;
            b_gdclk = n_gdclk;
            b_sdle  = n_sdle;
            axil_write(reg_ctrl, 32'd1, resp);
            check_reg(32'd0, resp, 32'd0, resp_okay, "start write");
            axil_read(reg_ctrl, data, resp);
            check_reg(data, resp, 32'd0, resp_okay, "ctrl after start");
            if (row.frames > 0) begin
                fork
                    send_video(row.img, row.frames, row.gaps);
                    begin
                        poll_busy(1'b1);
                        // Second start lands mid-run
                        axil_write(reg_ctrl, 32'd1, resp);
                        check_reg(32'd0, resp, 32'd0, resp_okay, "start while busy");
                        poll_busy(1'b0);
                    end
                join
            end else begin
                axil_read(reg_status, data, resp);
                check_reg(data, resp, 32'd0, resp_okay, "status after empty start");
                axil_read(reg_status, data, resp);
                check_reg(data, resp, 32'd0, resp_okay, "status after empty start");
            end
            axil_read(reg_count, data, resp);
            check_reg(data, resp, 32'(row.exp_count), resp_okay, "frame count");
            check_count(n_sdclk - b_sdclk, row.frames * N_BEATS, "sdclk pulses");
            check_count(n_gdsp - b_gdsp, row.frames, "gdsp pulses");
            check_count(n_gdclk - b_gdclk, row.frames * V_TOTAL, "gdclk pulses");
            check_count(n_sdle - b_sdle, row.frames * V_ACT, "sdle pulses");
            check_count(exp_q.size(), 0, "beats left without sdclk");
            check_count(int'(epd.gdoe || epd.sdoe), 0, "gdoe or sdoe after run");
            if (row.settle) begin
                check_count(int'(noop_streak >= N_BEATS), 1, "noop frame after settling");
            end
        end

        $display("Done: no errors");
        $finish;
    end

    // Limit scales with the frames in the table
    initial begin : watchdog
        int limit_ns;
        limit_ns = 40000;
        for (int i = 0; i < N_ROWS; i++) begin
            limit_ns += ROWS[i].frames * (FRAME_POS + 10) * 40;
        end
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $fatal(1);
    end

endmodule
